// ==== ahb_master.sv ====
////////////////////////////////////////////////////////////////////////////
// generic bus to AHB-Lite bridge, one single transfer per request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_master (
    input  logic              CLK,
    input  logic              nRST,
    input  ahb_pkg::gen_req_t gnt_req,
    output ahb_pkg::gen_rsp_t gnt_rsp,
    output ahb_pkg::ahb_req_t ahb_out,
    input  ahb_pkg::ahb_rsp_t ahb_in
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    state_t     state, next_state;
    logic       active;
    logic [2:0] size;
    logic [1:0] lane;

    assign active = gnt_req.ren | gnt_req.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // address phase and data phase each end on HREADY high
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (active) begin
                    next_state = ADDR;
                end
            end
            ADDR: begin
                if (ahb_in.HREADY) begin
                    next_state = DATA;
                end
            end
            DATA: begin
                if (ahb_in.HREADY) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // size and lowest lane follow from the contiguous byte enables
    always_comb begin
        size = ahb_pkg::HSIZE_WORD;
        lane = 2'd0;
        case (gnt_req.byte_en)
            4'b0011: begin
                size = ahb_pkg::HSIZE_HALF;
            end
            4'b1100: begin
                size = ahb_pkg::HSIZE_HALF;
                lane = 2'd2;
            end
            4'b0001: begin
                size = ahb_pkg::HSIZE_BYTE;
            end
            4'b0010: begin
                size = ahb_pkg::HSIZE_BYTE;
                lane = 2'd1;
            end
            4'b0100: begin
                size = ahb_pkg::HSIZE_BYTE;
                lane = 2'd2;
            end
            4'b1000: begin
                size = ahb_pkg::HSIZE_BYTE;
                lane = 2'd3;
            end
            // a full word and any unsupported pattern give a word transfer
            default: begin
                size = ahb_pkg::HSIZE_WORD;
                lane = 2'd0;
            end
        endcase
    end

    // the requester holds its request while busy, so address and
    // write data stay stable through the whole data phase
    always_comb begin
        ahb_out.HTRANS = (state == ADDR) ? ahb_pkg::HTRANS_NONSEQ : ahb_pkg::HTRANS_IDLE;
        ahb_out.HWRITE = (state != IDLE) && gnt_req.wen;
        ahb_out.HSIZE  = size;
        ahb_out.HADDR  = {gnt_req.addr[ahb_pkg::ADDR_W-1:2], lane};
        ahb_out.HWDATA = gnt_req.wdata;
    end

    // completion is the data phase cycle that sees HREADY
    assign gnt_rsp.busy  = !((state == DATA) && ahb_in.HREADY);
    assign gnt_rsp.rdata = ahb_in.HRDATA;

endmodule

// ==== ahb_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, AHB-Lite codes and bundled bus types for the
// two-port generic bus to AHB-Lite SRAM subsystem
////////////////////////////////////////////////////////////////////////////

package ahb_pkg;

    // bus widths, one byte enable per data byte
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // the sram holds this many words and the address wraps around it
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // cycles the slave keeps HREADY low in every data phase
    localparam int WAIT_STATES = 1;
    // counter width, kept at one bit even when no wait states are used
    localparam int WAIT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    // transfer type codes, only the two single-transfer ones are used
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // transfer size codes
    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // the slave never signals an error
    localparam logic HRESP_OKAY = 1'b0;

    // request from one processor-side port
    // the requester holds every field stable while busy is high
    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   byte_en;
    } gen_req_t;

    // answer to one port, busy low marks the completion cycle
    typedef struct packed {
        logic              busy;
        logic [DATA_W-1:0] rdata;
    } gen_rsp_t;

    // master to slave signals of a single AHB-Lite transfer
    // burst, protection and lock signals are left out
    typedef struct packed {
        logic [1:0]        HTRANS;
        logic              HWRITE;
        logic [2:0]        HSIZE;
        logic [ADDR_W-1:0] HADDR;
        logic [DATA_W-1:0] HWDATA;
    } ahb_req_t;

    // slave to master signals
    typedef struct packed {
        logic              HREADY;
        logic              HRESP;
        logic [DATA_W-1:0] HRDATA;
    } ahb_rsp_t;

endpackage

// ==== ahb_sram_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// AHB-Lite SRAM slave with byte lane writes and fixed wait states
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram_slave (
    input  logic              CLK,
    input  logic              nRST,
    input  ahb_pkg::ahb_req_t ahb_out,
    output ahb_pkg::ahb_rsp_t ahb_in
);

    logic                      ph_valid;
    logic                      ph_write;
    logic [2:0]                ph_size;
    logic [1:0]                ph_lane;
    logic [ahb_pkg::MEM_AW-1:0] ph_word;
    logic [ahb_pkg::WAIT_W-1:0] wait_cnt;
    logic                      hready;
    logic                      capture;
    logic                      finish;
    logic [ahb_pkg::BE_W-1:0]  lane_mask;
    logic [ahb_pkg::DATA_W-1:0] mem [ahb_pkg::MEM_WORDS];

    // HREADY is high outside a data phase and once the count runs out
    assign hready  = !ph_valid || (wait_cnt == '0);
    assign capture = (ahb_out.HTRANS == ahb_pkg::HTRANS_NONSEQ) && hready;
    assign finish  = ph_valid && (wait_cnt == '0);

    // data phase tracking and the wait state counter
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ph_valid <= 1'b0;
            wait_cnt <= '0;
        end else if (capture) begin
            ph_valid <= 1'b1;
            wait_cnt <= ahb_pkg::WAIT_W'(ahb_pkg::WAIT_STATES);
        end else if (finish) begin
            ph_valid <= 1'b0;
        end else if (ph_valid) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // address phase payload, only looked at while ph_valid is set
    always_ff @(posedge CLK) begin
        if (capture) begin
            ph_write <= ahb_out.HWRITE;
            ph_size  <= ahb_out.HSIZE;
            ph_lane  <= ahb_out.HADDR[1:0];
            // word index wraps modulo the memory depth
            ph_word  <= ahb_out.HADDR[ahb_pkg::MEM_AW+1:2];
        end
    end

    // lanes touched by the registered size and low address bits
    always_comb begin
        case (ph_size)
            ahb_pkg::HSIZE_BYTE: lane_mask = 4'b0001 << ph_lane;
            ahb_pkg::HSIZE_HALF: lane_mask = ph_lane[1] ? 4'b1100 : 4'b0011;
            default:             lane_mask = 4'b1111;
        endcase
    end

    // writes land in the cycle HREADY goes high with the data phase HWDATA
    // the array is cleared on reset so it starts from a known image
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ahb_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (finish && ph_write) begin
            for (int b = 0; b < ahb_pkg::BE_W; b++) begin
                if (lane_mask[b]) begin
                    mem[ph_word][8*b +: 8] <= ahb_out.HWDATA[8*b +: 8];
                end
            end
        end
    end

    // reads return the whole word, the master picks lanes if it needs to
    always_comb begin
        ahb_in.HREADY = hready;
        ahb_in.HRESP  = ahb_pkg::HRESP_OKAY;
        ahb_in.HRDATA = (finish && !ph_write) ? mem[ph_word] : '0;
    end

endmodule

// ==== ahb_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// two-port memory subsystem: arbiter, AHB-Lite bridge and SRAM slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_subsystem (
    input  logic              CLK,
    input  logic              nRST,
    input  ahb_pkg::gen_req_t iport_req,
    input  ahb_pkg::gen_req_t dport_req,
    output ahb_pkg::gen_rsp_t iport_rsp,
    output ahb_pkg::gen_rsp_t dport_rsp
);

    // granted request and its answer between arbiter and bridge
    ahb_pkg::gen_req_t gnt_req;
    ahb_pkg::gen_rsp_t gnt_rsp;

    // AHB-Lite signals between bridge and slave
    ahb_pkg::ahb_req_t ahb_out;
    ahb_pkg::ahb_rsp_t ahb_in;

    bus_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .iport_req (iport_req),
        .dport_req (dport_req),
        .iport_rsp (iport_rsp),
        .dport_rsp (dport_rsp),
        .gnt_req   (gnt_req),
        .gnt_rsp   (gnt_rsp)
    );

    ahb_master u_master (
        .CLK     (CLK),
        .nRST    (nRST),
        .gnt_req (gnt_req),
        .gnt_rsp (gnt_rsp),
        .ahb_out (ahb_out),
        .ahb_in  (ahb_in)
    );

    ahb_sram_slave u_slave (
        .CLK     (CLK),
        .nRST    (nRST),
        .ahb_out (ahb_out),
        .ahb_in  (ahb_in)
    );

endmodule

// ==== ahb_subsystem_sva.sv ====
////////////////////////////////////////////////////////////////////////////
// latency, AHB-Lite protocol and reset checks bound onto the subsystem
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_subsystem_sva (
    input logic              CLK,
    input logic              nRST,
    input ahb_pkg::gen_req_t iport_req,
    input ahb_pkg::gen_req_t dport_req,
    input ahb_pkg::gen_rsp_t iport_rsp,
    input ahb_pkg::gen_rsp_t dport_rsp,
    input ahb_pkg::ahb_req_t ahb_out,
    input ahb_pkg::ahb_rsp_t ahb_in
);

    logic d_req;
    logic i_req;
    logic d_req_q;
    logic i_req_q;
    logic d_alone;
    logic i_alone;
    logic nonseq;
    logic done;

    assign d_req  = dport_req.ren | dport_req.wen;
    assign i_req  = iport_req.ren;
    assign nonseq = ahb_out.HTRANS == ahb_pkg::HTRANS_NONSEQ;
    assign done   = !iport_rsp.busy || !dport_rsp.busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            d_req_q <= 1'b0;
            i_req_q <= 1'b0;
        end else begin
            d_req_q <= d_req;
            i_req_q <= i_req;
        end
    end

    // a new request while the other port has been quiet for a cycle
    assign d_alone = d_req && !d_req_q && !i_req && !i_req_q;
    assign i_alone = i_req && !i_req_q && !d_req && !d_req_q;

    a_dport_latency: assert property (@(posedge CLK) disable iff (!nRST)
        $past(d_alone, 3 + ahb_pkg::WAIT_STATES) |-> !dport_rsp.busy)
        else $error("data port completion missed its fixed latency");
    a_iport_latency: assert property (@(posedge CLK) disable iff (!nRST)
        $past(i_alone, 3 + ahb_pkg::WAIT_STATES) |-> !iport_rsp.busy)
        else $error("instruction port completion missed its fixed latency");

    // one address phase per transfer, the completion follows it
    a_nonseq_single: assert property (@(posedge CLK) disable iff (!nRST)
        nonseq |=> !nonseq) else $error("HTRANS NONSEQ held for more than one cycle");
    a_done_after_nonseq: assert property (@(posedge CLK) disable iff (!nRST)
        done |-> $past(nonseq, 1 + ahb_pkg::WAIT_STATES))
        else $error("completion without a matching address phase");

    a_hold_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
        !ahb_in.HREADY |=> $stable(ahb_out.HADDR) && $stable(ahb_out.HWRITE)
                           && $stable(ahb_out.HWDATA))
        else $error("master changed data phase signals while HREADY was low");
    a_hresp_okay: assert property (@(posedge CLK) ahb_in.HRESP == ahb_pkg::HRESP_OKAY)
        else $error("HRESP is not OKAY");

    a_reset_idle: assert property (@(posedge CLK)
        !nRST || $rose(nRST) |-> ahb_in.HREADY && ahb_out.HTRANS == ahb_pkg::HTRANS_IDLE)
        else $error("bus not idle with HREADY high around reset");

endmodule

// ==== bus_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// fixed-priority arbiter between the instruction and data ports,
// holding the grant for the whole transfer of the winner
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  ahb_pkg::gen_req_t iport_req,
    input  ahb_pkg::gen_req_t dport_req,
    output ahb_pkg::gen_rsp_t iport_rsp,
    output ahb_pkg::gen_rsp_t dport_rsp,
    output ahb_pkg::gen_req_t gnt_req,
    input  ahb_pkg::gen_rsp_t gnt_rsp
);

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_I,
        OWNER_D
    } owner_t;

    owner_t owner, next_owner;
    logic   d_wants;
    logic   i_wants;
    logic   done;

    // the instruction port can only read, so its wen never counts as a request
    assign d_wants = dport_req.ren | dport_req.wen;
    assign i_wants = iport_req.ren;

    // busy only drops in the completion cycle of the granted transfer
    assign done = (owner != OWNER_NONE) && !gnt_rsp.busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= OWNER_NONE;
        end else begin
            owner <= next_owner;
        end
    end

    always_comb begin
        next_owner = owner;
        if (owner == OWNER_NONE) begin
            // data port has priority when both ask in the same cycle
            if (d_wants) begin
                next_owner = OWNER_D;
            end else if (i_wants) begin
                next_owner = OWNER_I;
            end
        end else if (done) begin
            // the owner is let go in the cycle after its completion
            next_owner = OWNER_NONE;
        end
    end

    // only the owner's request reaches the bridge
    always_comb begin
        gnt_req = '0;
        case (owner)
            OWNER_I: begin
                gnt_req       = iport_req;
                gnt_req.wen   = 1'b0;
                gnt_req.wdata = '0;
            end
            OWNER_D: begin
                gnt_req = dport_req;
            end
            default: begin
                gnt_req = '0;
            end
        endcase
    end

    // a port that does not own the bus just sees busy
    always_comb begin
        iport_rsp.busy  = 1'b1;
        iport_rsp.rdata = '0;
        dport_rsp.busy  = 1'b1;
        dport_rsp.rdata = '0;
        if (owner == OWNER_I) begin
            iport_rsp = gnt_rsp;
        end
        if (owner == OWNER_D) begin
            dport_rsp = gnt_rsp;
        end
    end

endmodule

// ==== compile.f ====
ahb_pkg.sv
bus_arbiter.sv
ahb_master.sv
ahb_sram_slave.sv
ahb_subsystem.sv
ahb_subsystem_sva.sv
tb_ahb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ahb_subsystem -f compile.f -o sim_tb

# a failing run exits non-zero, the log is searched either way
if ./obj_dir/sim_tb > sim.log 2>&1; then
    :
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation stopped without a pass result"
    exit 1
fi
echo "simulation passed"

// ==== tb_ahb_subsystem.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the two-port AHB-Lite memory subsystem: random word and
// lane writes, aliased read-back, port arbitration and a reference memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ahb_subsystem;

    logic              CLK;
    logic              nRST;
    ahb_pkg::gen_req_t iport_req;
    ahb_pkg::gen_req_t dport_req;
    ahb_pkg::gen_rsp_t iport_rsp;
    ahb_pkg::gen_rsp_t dport_rsp;

    // rounds of the word, lane and arbitration phases
    int word_rounds = 16;
    int lane_rounds = 2;
    int arb_rounds  = 4;

    logic [31:0]                lfsr = 32'h17c455d0;
    logic [ahb_pkg::DATA_W-1:0] model [ahb_pkg::MEM_WORDS];
    logic [ahb_pkg::ADDR_W-1:0] used_addr [$];
    // every contiguous byte enable the bridge accepts
    logic [ahb_pkg::BE_W-1:0]   lane_pats [7] = '{4'b1111, 4'b0011, 4'b1100,
                                                  4'b0001, 4'b0010, 4'b0100, 4'b1000};

    ahb_subsystem uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .iport_req (iport_req),
        .dport_req (dport_req),
        .iport_rsp (iport_rsp),
        .dport_rsp (dport_rsp)
    );

    bind ahb_subsystem ahb_subsystem_sva u_sva (
        .CLK       (CLK),
        .nRST      (nRST),
        .iport_req (iport_req),
        .dport_req (dport_req),
        .iport_rsp (iport_rsp),
        .dport_rsp (dport_rsp),
        .ahb_out   (ahb_out),
        .ahb_in    (ahb_in)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // every phase issues two transfers per step
    function automatic int planned_txn();
        return 2 * word_rounds + 2 * 7 * lane_rounds + 2 * arb_rounds;
    endfunction

    // each transfer gets twice its own latency before the run is given up
    initial begin
        #(planned_txn() * 2 * (3 + ahb_pkg::WAIT_STATES) * 100);
        $display("watchdog expired before all transfers were done");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    task automatic fail_now(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // a ten bit word index covers four times the memory, so addresses alias
    task automatic make_write(input logic [ahb_pkg::BE_W-1:0] be,
                              output ahb_pkg::gen_req_t r);
        logic [31:0] word;
        logic [31:0] data;
        take_bits(10, word);
        take_bits(32, data);
        r         = '0;
        r.wen     = 1'b1;
        r.addr    = {word[29:0], 2'b00};
        r.wdata   = data;
        r.byte_en = be;
    endtask

    function automatic ahb_pkg::gen_req_t word_read(input logic [ahb_pkg::ADDR_W-1:0] addr);
        ahb_pkg::gen_req_t r;
        r         = '0;
        r.ren     = 1'b1;
        r.addr    = addr;
        r.byte_en = 4'b1111;
        return r;
    endfunction

    function automatic int model_index(input logic [ahb_pkg::ADDR_W-1:0] addr);
        return int'((addr >> 2) % ahb_pkg::MEM_WORDS);
    endfunction

    // writes update only the enabled lanes, reads must match the model word
    task automatic finish_txn(input ahb_pkg::gen_req_t req,
                              input logic [ahb_pkg::DATA_W-1:0] rdata);
        int idx;
        idx = model_index(req.addr);
        if (req.wen) begin
            for (int b = 0; b < ahb_pkg::BE_W; b++) begin
                if (req.byte_en[b]) begin
                    model[idx][8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end else begin
            assert (rdata == model[idx]) else fail_now($sformatf(
                "read of %h returned %h, expected %h", req.addr, rdata, model[idx]));
        end
    endtask

    task automatic check_busy_high(input string msg);
        assert (iport_rsp.busy && dport_rsp.busy) else fail_now(msg);
    endtask

    // present one request per port in the same cycle and hold each until
    // its completion, an idle port is passed as all zeros
    task automatic run_ports(input ahb_pkg::gen_req_t d, input ahb_pkg::gen_req_t i);
        logic d_open;
        logic i_open;
        logic d_drop;
        logic i_drop;
        d_open = d.ren | d.wen;
        i_open = i.ren;
        @(posedge CLK);
        dport_req <= d;
        iport_req <= i;
        while (d_open || i_open) begin
            d_drop = 1'b0;
            i_drop = 1'b0;
            @(negedge CLK);
            if (d_open && !dport_rsp.busy) begin
                finish_txn(d, dport_rsp.rdata);
                d_open = 1'b0;
                d_drop = 1'b1;
            end
            if (i_open && !iport_rsp.busy) begin
                // the data port has priority and must be served first
                assert (!d_open) else fail_now("instruction port completed before data port");
                finish_txn(i, iport_rsp.rdata);
                i_open = 1'b0;
                i_drop = 1'b1;
            end
            @(posedge CLK);
            if (d_drop) begin
                dport_req <= '0;
            end
            if (i_drop) begin
                iport_req <= '0;
            end
        end
    endtask

    initial begin
        ahb_pkg::gen_req_t wr;
        ahb_pkg::gen_req_t none;
        nRST      = 1'b0;
        iport_req = '0;
        dport_req = '0;
        none      = '0;
        for (int k = 0; k < ahb_pkg::MEM_WORDS; k++) begin
            model[k] = '0;
        end
        @(posedge CLK);
        @(negedge CLK);
        check_busy_high("a port showed busy low during reset");
        @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_busy_high("a port showed busy low right after reset");

        // word writes read back one memory size higher, alternating ports
        for (int r = 0; r < word_rounds; r++) begin
            make_write(4'b1111, wr);
            used_addr.push_back(wr.addr);
            run_ports(wr, none);
            if (r[0]) begin
                run_ports(none, word_read(wr.addr ^ ahb_pkg::ADDR_W'(ahb_pkg::MEM_WORDS * 4)));
            end else begin
                run_ports(word_read(wr.addr ^ ahb_pkg::ADDR_W'(ahb_pkg::MEM_WORDS * 4)), none);
            end
        end

        // lane writes over words that already hold random data
        for (int r = 0; r < lane_rounds; r++) begin
            for (int p = 0; p < 7; p++) begin
                make_write(lane_pats[p], wr);
                wr.addr = used_addr[(r * 7 + p) % used_addr.size()];
                run_ports(wr, none);
                run_ports(word_read(wr.addr), none);
            end
        end

        // both ports at once on the same word, the read sees the new data
        for (int r = 0; r < arb_rounds; r++) begin
            make_write(4'b1111, wr);
            run_ports(wr, word_read(wr.addr));
        end

        @(posedge CLK);
        $display("TEST OK");
        $finish;
    end

endmodule
